//--- sources.f
verilog/fp80_pkg.sv
verilog/fp80_decomp_if.sv
verilog/fp80_decomp.sv
verilog/fp80_compare.sv
verilog/fp80_minmax.sv
verilog/fp80_cmp_ctrl.sv
verilog/fp80_cmp_unit.sv
tb/tb_fp80_cmp_unit.sv

//--- Bender.yml
package:
  name: fp80_cmp_unit

sources:
  # package and interface first, then leaf modules, then the top level
  - verilog/fp80_pkg.sv
  - verilog/fp80_decomp_if.sv
  - verilog/fp80_decomp.sv
  - verilog/fp80_compare.sv
  - verilog/fp80_minmax.sv
  - verilog/fp80_cmp_ctrl.sv
  - verilog/fp80_cmp_unit.sv

  - target: test
    files:
      - tb/tb_fp80_cmp_unit.sv

//--- tb/tb_fp80_cmp_unit.sv
`timescale 1ns/1ns

module tb_fp80_cmp_unit
	import fp80_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	// start driven at an edge and done seen at the negedge after the second edge
	localparam int DONE_DELAY = 2 * CLK_PERIOD + CLK_PERIOD / 2;
	localparam int MAX_CYCLES = 2000;

	// expected reply with t the time start went high
	typedef struct packed
	{
		fp80_t res;
		logic nan;
		logic snan;
		logic inf;
		logic un;
		logic [63:0] t;
	} exp_t;

	logic clk = 1'b0;
	logic arst_n;
	logic start;
	fp80_op_e op;
	fp80_t a;
	fp80_t b;
	logic clear_flags;
	logic done;
	fp80_t result;
	logic nan;
	logic snan;
	logic inf;
	logic sticky_invalid;
	logic sticky_unordered;

	exp_t exp_q[$];
	exp_t head;
	logic [31:0] lfsr = 32'h5206_7e84;
	// sticky model set by the checker and cleared by stimulus
	logic exp_sinv = 1'b0;
	logic exp_sun = 1'b0;
	int errors = 0;
	int checks = 0;
	logic run_over = 1'b0;
	logic timed_out = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	fp80_cmp_unit fp80_cmp_unit_inst (
		.clk(clk), .arst_n(arst_n), .start(start), .op(op), .a(a), .b(b),
		.clear_flags(clear_flags), .done(done), .result(result), .nan(nan), .snan(snan),
		.inf(inf), .sticky_invalid(sticky_invalid), .sticky_unordered(sticky_unordered)
	);

	// ==============================
	// random source
	// ==============================

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit handed out
	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	// exponents kept in a narrow band so equal exponents show up often
	function automatic fp80_t random_number();
		fp80_t r;
		r.sgn = take_bits(1) != 0;
		r.exp = 15'h3FF8 + 15'(take_bits(4));
		r.man = {1'b1, 63'(take_bits(63))};
		return r;
	endfunction

	// 0 zero, 1 inf, 2 quiet nan, 3 signalling nan, else a number
	function automatic fp80_t class_operand(input int kind);
		fp80_t r;
		r.sgn = take_bits(1) != 0;
		r.exp = EXP_MAX;
		case (kind)
			0: r = {r.sgn, 79'd0};
			1: r.man = 64'h8000_0000_0000_0000;
			2: r.man = {2'b11, 62'(take_bits(62))};
			// low bit forced so the fraction is never zero
			3: r.man = {2'b10, 61'(take_bits(61)), 1'b1};
			default: r = random_number();
		endcase
		return r;
	endfunction

	// ==============================
	// reference model
	// ==============================

	function automatic logic is_nan(input fp80_t x);
		return (x.exp == EXP_MAX) && (x.man[QBIT:0] != '0);
	endfunction

	function automatic logic is_inf(input fp80_t x);
		return (x.exp == EXP_MAX) && (x.man[QBIT:0] == '0);
	endfunction

	function automatic logic is_zero(input fp80_t x);
		return (x.exp == '0) && (x.man == '0);
	endfunction

	// strict signed order of two non nan values with zeros equal
	function automatic logic signed_less(input fp80_t x, input fp80_t y);
		if (is_zero(x) && is_zero(y))
			return 1'b0;
		if (x.sgn != y.sgn)
			return x.sgn;
		if (x.sgn)
			return {y.exp, y.man} < {x.exp, x.man};
		return {x.exp, x.man} < {y.exp, y.man};
	endfunction

	function automatic logic [15:0] predicate_mask(input fp80_t x, input fp80_t y);
		logic un;
		logic eq;
		logic lt;
		logic mlt;
		logic [15:0] m;
		un = is_nan(x) || is_nan(y);
		eq = (x == y) || (is_zero(x) && is_zero(y));
		lt = signed_less(x, y);
		mlt = {x.exp, x.man} < {y.exp, y.man};
		m = '0;
		m[CMP_EQ] = eq && !un;
		m[CMP_LT] = lt && !un;
		m[CMP_LE] = (lt || eq) && !un;
		m[CMP_MAGLT] = mlt;
		m[CMP_UN] = un;
		m[CMP_NE] = !eq || un;
		m[CMP_GE] = !lt && !un;
		m[CMP_GT] = !lt && !eq && !un;
		m[CMP_MAGGE] = !mlt;
		m[CMP_OR] = !un;
		return m;
	endfunction

	function automatic fp80_t select_minmax(input fp80_t x, input fp80_t y, input logic mx);
		if (is_nan(x) && is_nan(y))
			return CANON_QNAN;
		if (is_nan(x))
			return y;
		if (is_nan(y))
			return x;
		// two zeros keep x unless only y carries the preferred sign
		if (is_zero(x) && is_zero(y))
		begin
			if (mx)
				return (x.sgn && !y.sgn) ? y : x;
			return (!x.sgn && y.sgn) ? y : x;
		end
		if (mx)
			return signed_less(x, y) ? y : x;
		return signed_less(y, x) ? y : x;
	endfunction

	function automatic exp_t expected_reply(input fp80_t x, input fp80_t y, input fp80_op_e o);
		exp_t e;
		logic [15:0] m;
		m = predicate_mask(x, y);
		e = '0;
		e.nan = is_nan(x) || is_nan(y) || (is_inf(x) && is_inf(y));
		e.snan = (is_nan(x) && !x.man[QBIT]) || (is_nan(y) && !y.man[QBIT]);
		e.inf = is_inf(x) || is_inf(y);
		e.un = (o == OP_CMP) && m[CMP_UN];
		if (o == OP_CMP)
			e.res = {64'd0, m};
		else
			e.res = select_minmax(x, y, o == OP_MAX);
		return e;
	endfunction

	// ==============================
	// checking
	// ==============================

	task automatic check_value(input string name, input logic [79:0] got, input logic [79:0] want);
		checks++;
		if (got !== want)
		begin
			$display("FAILED %s got %h expected %h at %0t", name, got, want, $time);
			errors++;
		end
	endtask

	// every done is matched to the oldest outstanding start
	always @(negedge clk)
	begin
		if (arst_n && done)
		begin
			if (exp_q.size() == 0)
			begin
				$display("done pulse with no operation outstanding at %0t", $time);
				errors++;
			end
			else
			begin
				head = exp_q.pop_front();
				if ($time != head.t + DONE_DELAY)
				begin
					$display("done came at %0t, expected at %0t", $time, head.t + DONE_DELAY);
					errors++;
				end
				if (head.snan)
					exp_sinv = 1'b1;
				if (head.un)
					exp_sun = 1'b1;
				check_value("result", result, head.res);
				check_value("nan", nan, head.nan);
				check_value("snan", snan, head.snan);
				check_value("inf", inf, head.inf);
				check_value("sticky_invalid", sticky_invalid, exp_sinv);
				check_value("sticky_unordered", sticky_unordered, exp_sun);
			end
		end
	end

	// ==============================
	// stimulus helpers
	// ==============================

	task automatic issue(input fp80_op_e o, input fp80_t x, input fp80_t y);
		exp_t e;
		@(posedge clk);
		e = expected_reply(x, y, o);
		e.t = $time;
		exp_q.push_back(e);
		start <= 1'b1;
		op <= o;
		a <= x;
		b <= y;
	endtask

	task automatic go_idle();
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			$display("timeout, %0d results never arrived", exp_q.size());
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic check_sticky();
		@(negedge clk);
		check_value("sticky_invalid", sticky_invalid, exp_sinv);
		check_value("sticky_unordered", sticky_unordered, exp_sun);
	endtask

	task automatic clear_sticky();
		@(posedge clk);
		clear_flags <= 1'b1;
		exp_sinv = 1'b0;
		exp_sun = 1'b0;
		@(posedge clk);
		clear_flags <= 1'b0;
	endtask

	function automatic fp80_op_e random_op();
		case (take_bits(2))
			1: return OP_MIN;
			2: return OP_MAX;
			default: return OP_CMP;
		endcase
	endfunction

	// ==============================
	// test sequence
	// ==============================

	initial
	begin : stimulus
		fp80_t x;
		fp80_t y;
		arst_n = 1'b0;
		start = 1'b0;
		op = OP_CMP;
		a = '0;
		b = '0;
		clear_flags = 1'b0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		// idle state straight out of reset
		@(negedge clk);
		check_value("done", done, 1'b0);
		check_value("result", result, '0);
		check_value("nan", nan, 1'b0);
		check_value("snan", snan, 1'b0);
		check_value("inf", inf, 1'b0);
		check_sticky();

		// ordered compares with some equal operands
		for (int i = 0; i < 40; i++)
		begin
			x = random_number();
			y = (take_bits(3) == 0) ? x : random_number();
			issue(OP_CMP, x, y);
		end
		go_idle();
		wait_drained();

		// signed zeros both ways
		x = {1'b0, 79'd0};
		y = {1'b1, 79'd0};
		issue(OP_CMP, x, y);
		issue(OP_MIN, x, y);
		issue(OP_MAX, x, y);
		issue(OP_MIN, y, x);
		issue(OP_MAX, y, x);
		go_idle();
		wait_drained();
		check_sticky();

		// nan and infinity classes
		issue(OP_CMP, class_operand(2), random_number());
		issue(OP_CMP, random_number(), class_operand(3));
		x = {1'b0, EXP_MAX, 64'h8000_0000_0000_0000};
		y = {1'b1, EXP_MAX, 64'h8000_0000_0000_0000};
		issue(OP_CMP, x, y);
		issue(OP_CMP, x, x);
		go_idle();
		wait_drained();
		// both sticky flags set here and then cleared
		check_sticky();
		clear_sticky();
		check_sticky();

		// back to back mix of opcodes and classes
		for (int i = 0; i < 80; i++)
		begin
			x = class_operand(int'(take_bits(3)));
			y = (take_bits(3) == 0) ? x : class_operand(int'(take_bits(3)));
			issue(random_op(), x, y);
		end
		go_idle();
		wait_drained();
		check_sticky();
		clear_sticky();

		// clean ops leave cleared flags alone
		issue(OP_MIN, random_number(), random_number());
		issue(OP_CMP, random_number(), random_number());
		go_idle();
		wait_drained();
		check_sticky();

		// set and clear on the same edge where the set wins
		issue(OP_CMP, class_operand(3), random_number());
		@(posedge clk);
		start <= 1'b0;
		clear_flags <= 1'b1;
		exp_sinv = 1'b0;
		exp_sun = 1'b0;
		@(posedge clk);
		clear_flags <= 1'b0;
		wait_drained();
		check_sticky();
		clear_sticky();
		check_sticky();
		run_over = 1'b1;
	end

	// ends the run on completion, on a timeout or at the cycle limit
	initial
	begin : report
		int cycles;
		cycles = 0;
		while (!run_over && !timed_out && cycles < MAX_CYCLES)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!run_over && !timed_out)
		begin
			$display("run did not finish within %0d cycles", MAX_CYCLES);
			errors++;
		end
		$display("errors %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- verilog/fp80_cmp_unit.sv
`timescale 1ns/1ns

module fp80_cmp_unit
	import fp80_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic start,
	input fp80_op_e op,
	input fp80_t a,
	input fp80_t b,
	input logic clear_flags,
	output logic done,
	output fp80_t result,
	output logic nan,
	output logic snan,
	output logic inf,
	output logic sticky_invalid,
	output logic sticky_unordered
);

	// registered operands into the datapath
	fp80_t ra;
	fp80_t rb;
	logic take_max;
	// datapath back to control
	logic [15:0] mask;
	fp80_t sel_res;
	logic c_nan;
	logic c_snan;
	logic c_inf;

	fp80_decomp_if da_if ();
	fp80_decomp_if db_if ();

	// ==============================
	// control and pipeline registers
	// ==============================

	fp80_cmp_ctrl ctrl_inst (
		.clk(clk), .arst_n(arst_n), .start(start), .op(op), .a(a), .b(b),
		.clear_flags(clear_flags), .ra(ra), .rb(rb), .take_max(take_max),
		.mask(mask), .sel_res(sel_res), .c_nan(c_nan), .c_snan(c_snan), .c_inf(c_inf),
		.done(done), .result(result), .nan(nan), .snan(snan), .inf(inf),
		.sticky_invalid(sticky_invalid), .sticky_unordered(sticky_unordered)
	);

	// ==============================
	// combinational datapath
	// ==============================

	// one decomposer per operand
	fp80_decomp decomp_a_inst (.i(ra), .d(da_if.src));
	fp80_decomp decomp_b_inst (.i(rb), .d(db_if.src));

	fp80_compare compare_inst (
		.da(da_if.dst), .db(db_if.dst), .mask(mask),
		.nan(c_nan), .snan(c_snan), .inf(c_inf)
	);

	fp80_minmax minmax_inst (
		.da(da_if.dst), .db(db_if.dst), .take_max(take_max), .sel_res(sel_res)
	);

endmodule

//--- verilog/fp80_cmp_ctrl.sv
`timescale 1ns/1ns

module fp80_cmp_ctrl
	import fp80_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic start,
	input fp80_op_e op,
	input fp80_t a,
	input fp80_t b,
	input logic clear_flags,
	output fp80_t ra,
	output fp80_t rb,
	output logic take_max,
	input logic [15:0] mask,
	input fp80_t sel_res,
	input logic c_nan,
	input logic c_snan,
	input logic c_inf,
	output logic done,
	output fp80_t result,
	output logic nan,
	output logic snan,
	output logic inf,
	output logic sticky_invalid,
	output logic sticky_unordered
);

	// stage 1 state
	logic s1_valid;
	fp80_op_e s1_op;
	// sticky set conditions for the op finishing this cycle
	logic set_invalid;
	logic set_unordered;

	// ==============================
	// stage 1 capture
	// ==============================

	// operand registers loaded on start
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ra <= '0;
			rb <= '0;
		end
		else if (start)
		begin
			ra <= a;
			rb <= b;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			s1_valid <= 1'b0;
			s1_op <= OP_CMP;
		end
		else
		begin
			s1_valid <= start;
			if (start)
				s1_op <= op;
		end
	end

	// min/max direction straight from the stage 1 opcode
	assign take_max = (s1_op == OP_MAX);

	// ==============================
	// stage 2 result and flags
	// ==============================

	assign set_invalid = s1_valid & c_snan;
	assign set_unordered = s1_valid & (s1_op == OP_CMP) & mask[CMP_UN];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			done <= 1'b0;
			result <= '0;
			nan <= 1'b0;
			snan <= 1'b0;
			inf <= 1'b0;
			sticky_invalid <= 1'b0;
			sticky_unordered <= 1'b0;
		end
		else
		begin
			// single cycle pulse for each stage 1 op
			done <= s1_valid;
			// result and flags hold until the next op lands
			if (s1_valid)
			begin
				result <= (s1_op == OP_CMP) ? fp80_t'({64'd0, mask}) : sel_res;
				nan <= c_nan;
				snan <= c_snan;
				inf <= c_inf;
			end
			// a set in the same cycle beats the clear
			if (set_invalid)
				sticky_invalid <= 1'b1;
			else if (clear_flags)
				sticky_invalid <= 1'b0;
			if (set_unordered)
				sticky_unordered <= 1'b1;
			else if (clear_flags)
				sticky_unordered <= 1'b0;
		end
	end

	// every done traces back to a valid stage 1 slot
	assert property (@(posedge clk) disable iff (!arst_n) done |-> $past(s1_valid))
		else $error("fp80_cmp_ctrl done without stage 1 valid");

	assert property (@(posedge clk) disable iff (!arst_n)
		start |-> (op inside {OP_CMP, OP_MIN, OP_MAX}))
		else $error("fp80_cmp_ctrl start with unused opcode");

endmodule

//--- verilog/fp80_minmax.sv
`timescale 1ns/1ns

module fp80_minmax
	import fp80_pkg::*;
(
	fp80_decomp_if.dst da,
	fp80_decomp_if.dst db,
	input logic take_max,
	output fp80_t sel_res
);

	logic a_nan;
	logic b_nan;
	logic both_zero;
	// strict signed order, each direction
	logic a_lt_b;
	logic b_lt_a;

	// either flavour of nan counts
	assign a_nan = da.qnan | da.snan;
	assign b_nan = db.qnan | db.snan;

	assign both_zero = da.vz & db.vz;

	// signs differ means the negative side is smaller
	// zeros are resolved separately below
	assign a_lt_b = (da.sgn != db.sgn) ? da.sgn :
		da.sgn ? ({da.exp, da.man} > {db.exp, db.man}) :
		({da.exp, da.man} < {db.exp, db.man});
	assign b_lt_a = (da.sgn != db.sgn) ? db.sgn :
		da.sgn ? ({db.exp, db.man} > {da.exp, da.man}) :
		({db.exp, db.man} < {da.exp, da.man});

	// ==============================
	// selection
	// ==============================

	always_comb
	begin
		if (a_nan && b_nan)
			sel_res = CANON_QNAN;
		// one nan, the number wins
		else if (a_nan)
			sel_res = db.raw;
		else if (b_nan)
			sel_res = da.raw;
		// min leans to -0, max to +0
		else if (both_zero)
			sel_res = (take_max ? (~da.sgn | db.sgn) : (da.sgn | ~db.sgn)) ? da.raw : db.raw;
		// a kept on a tie
		else if (take_max)
			sel_res = a_lt_b ? db.raw : da.raw;
		else
			sel_res = b_lt_a ? db.raw : da.raw;
	end

	always_comb
	begin
		assert final (sel_res == da.raw || sel_res == db.raw || sel_res == CANON_QNAN)
			else $error("fp80_minmax result is neither operand nor canonical nan");
	end

endmodule

//--- verilog/fp80_compare.sv
`timescale 1ns/1ns

module fp80_compare
	import fp80_pkg::*;
(
	fp80_decomp_if.dst da,
	fp80_decomp_if.dst db,
	output logic [15:0] mask,
	output logic nan,
	output logic snan,
	output logic inf
);

	// magnitude order of the exponent and mantissa concatenation
	logic mag_lt;
	logic mag_gt;
	logic mag_eq;
	// both operands zero with either sign
	logic both_zero;
	// signed order before nan masking
	logic eq;
	logic lt;
	logic unordered;

	// ==============================
	// ordering
	// ==============================

	// exponent is biased so the concatenation orders as unsigned
	assign mag_lt = {da.exp, da.man} < {db.exp, db.man};
	assign mag_gt = {da.exp, da.man} > {db.exp, db.man};
	assign mag_eq = {da.exp, da.man} == {db.exp, db.man};

	assign both_zero = da.vz & db.vz;

	// +0 and -0 compare equal
	assign eq = both_zero | (mag_eq & (da.sgn == db.sgn));

	// with differing signs the negative one is smaller unless both are zero
	// with equal signs negative values flip the magnitude order
	always_comb
	begin
		if (da.sgn != db.sgn)
			lt = da.sgn & ~both_zero;
		else if (da.sgn)
			lt = mag_gt;
		else
			lt = mag_lt;
	end

	assign unordered = da.nan | db.nan;

	// ==============================
	// predicate mask
	// ==============================

	always_comb
	begin
		mask = '0;
		// ordered predicates drop out when a nan is present
		mask[CMP_EQ]    = eq & ~unordered;
		mask[CMP_LT]    = lt & ~unordered;
		mask[CMP_LE]    = (lt | eq) & ~unordered;
		// magnitude bits ignore sign and nan
		mask[CMP_MAGLT] = mag_lt;
		mask[CMP_UN]    = unordered;
		// NE is the complement of EQ so any nan sets it
		mask[CMP_NE]    = ~eq | unordered;
		mask[CMP_GE]    = ~lt & ~unordered;
		mask[CMP_GT]    = ~(lt | eq) & ~unordered;
		mask[CMP_MAGGE] = ~mag_lt;
		mask[CMP_OR]    = ~unordered;
	end

	// exception indications
	// inf against inf is flagged as nan as well
	assign nan  = da.nan | db.nan | (da.inf & db.inf);
	assign snan = da.snan | db.snan;
	assign inf  = da.inf | db.inf;

	// equal and less can never hold together
	always_comb
	begin
		assert final (!(mask[CMP_EQ] && mask[CMP_LT]))
			else $error("fp80_compare EQ and LT both set");
	end

endmodule

//--- verilog/fp80_decomp.sv
`timescale 1ns/1ns

module fp80_decomp
	import fp80_pkg::*;
(
	input fp80_t i,
	fp80_decomp_if.src d
);

	// exponent saturated
	logic exp_ones;
	// fraction below the integer bit is nonzero
	logic frac_nz;

	// ==============================
	// raw fields
	// ==============================

	assign d.raw = i;
	assign d.sgn = i.sgn;
	assign d.exp = i.exp;
	assign d.man = i.man;

	// ==============================
	// classification
	// ==============================

	assign exp_ones = (i.exp == EXP_MAX);

	// integer bit is excluded here, so a pseudo infinity
	// with bit 63 clear still counts as infinity
	assign frac_nz = |i.man[QBIT:0];

	// true zero needs every exponent and mantissa bit clear
	assign d.vz = (i.exp == '0) && (i.man == '0);

	assign d.inf = exp_ones & ~frac_nz;
	assign d.nan = exp_ones & frac_nz;

	// quiet bit picks the nan flavour
	assign d.qnan = d.nan & i.man[QBIT];
	assign d.snan = d.nan & ~i.man[QBIT];

	// integer bit carried along in man for the magnitude compare
	// nothing else here looks at i.man[FMSB]

endmodule

//--- verilog/fp80_decomp_if.sv
`timescale 1ns/1ns

// one operand split into fields and class flags
interface fp80_decomp_if
	import fp80_pkg::*;
();

	// untouched operand, needed by min/max for selection
	fp80_t raw;
	logic sgn;
	logic [EMSB:0] exp;
	logic [FMSB:0] man;
	// class flags
	logic vz;
	logic inf;
	logic nan;
	logic qnan;
	logic snan;

	// decomposer side drives every field
	modport src (output raw, sgn, exp, man, vz, inf, nan, qnan, snan);

	// compare and min/max only look
	modport dst (input raw, sgn, exp, man, vz, inf, nan, qnan, snan);

endinterface

//--- verilog/fp80_pkg.sv
package fp80_pkg;

	// ==============================
	// operand format
	// ==============================

	// exponent msb, 15 bit biased exponent
	localparam int EMSB = 14;
	// mantissa msb, bit 63 is the explicit integer bit
	localparam int FMSB = 63;
	// quiet bit sits just below the integer bit
	localparam int QBIT = 62;

	// all ones exponent marks inf and nan
	localparam logic [EMSB:0] EXP_MAX = '1;

	// one extended precision operand, 80 bits total
	typedef struct packed
	{
		logic sgn;
		logic [EMSB:0] exp;
		logic [FMSB:0] man;
	} fp80_t;

	// ==============================
	// opcodes
	// ==============================

	// encoding 2'b11 is unused
	typedef enum logic [1:0]
	{
		OP_CMP = 2'd0,
		OP_MIN = 2'd1,
		OP_MAX = 2'd2
	} fp80_op_e;

	// ==============================
	// predicate mask bits
	// ==============================

	// lower byte holds the "true" sense predicates
	localparam int CMP_EQ    = 0;
	localparam int CMP_LT    = 1;
	localparam int CMP_LE    = 2;
	// magnitude only, sign ignored
	localparam int CMP_MAGLT = 3;
	localparam int CMP_UN    = 4;
	// bits 5..7 always zero

	// upper byte holds the complements
	localparam int CMP_NE    = 8;
	localparam int CMP_GE    = 9;
	localparam int CMP_GT    = 10;
	localparam int CMP_MAGGE = 11;
	localparam int CMP_OR    = 12;
	// bits 13..15 always zero

	// canonical quiet nan returned when min/max sees two nans
	// integer and quiet bits set, rest of fraction clear
	localparam fp80_t CANON_QNAN = '{
		sgn: 1'b0,
		exp: EXP_MAX,
		man: 64'hC000_0000_0000_0000
	};

endpackage
